//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_reg_hub
SEED      ?= 1
LOG       ?= sim.log
FILELIST  ?= reg_hub_top.f
OBJ_DIR   ?= obj_dir
FAIL_MSG  := Simulation failed
PASS_MSG  := Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --timing -j 0 --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "failure reported in $(LOG)"; exit 1; \
	fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "run in $(LOG) did not complete"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/tb_reg_hub.sv
`default_nettype none

module tb_reg_hub;
    timeunit 1ns;
    timeprecision 100ps;

    import reg_hub_pkg::*;

    localparam int unsigned SEED = 32'hdbd2a286;
    localparam int WAIT_LIMIT = 200;
    localparam logic [ADDR_W-1:0] EXT_BASE = 16'h1000;
    localparam logic [ADDR_W-1:0] NONE_BASE = 16'h2000;

    logic              clk;
    logic              rstn;
    logic [ADDR_W-1:0] paddr;
    logic              pwrite;
    logic              psel;
    logic              penable;
    logic [DATA_W-1:0] pwdata;
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;
    logic              interrupt;
    logic [ADDR_W-1:0] fault_addr;
    logic              clear;

    int mismatches;
    int failures;

    // expected register contents
    logic [DATA_W-1:0] ctrl_model [0:6];
    logic [DATA_W-1:0] ext_model [1:3];

    reg_hub_top UUT (.*);

    always #4 clk = ~clk;

    task automatic check_data(input string name, input logic [DATA_W-1:0] expected,
                              input logic [DATA_W-1:0] actual);
        if (actual !== expected) begin
            $display("mismatch at %0d ns: %s expected %h got %h", $time, name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("mismatch at %0d ns: %s expected %b got %b", $time, name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] expected,
                              input logic [ADDR_W-1:0] actual);
        if (actual !== expected) begin
            $display("mismatch at %0d ns: %s expected %h got %h", $time, name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic finish_run();
        $display("error count: %0d (%0d mismatches, %0d other failures)",
                 mismatches + failures, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    function automatic logic [ADDR_W-1:0] ctrl_addr(input int word);
        return ADDR_W'(word * 4);
    endfunction

    function automatic logic [ADDR_W-1:0] ext_addr(input int word);
        return EXT_BASE | ADDR_W'(word * 4);
    endfunction

    // pready is sampled at the falling edge of each access cycle
    task automatic apb_transfer(input logic write, input logic [ADDR_W-1:0] addr,
                                input logic [DATA_W-1:0] wdata,
                                output logic [DATA_W-1:0] rdata, output logic err);
        int n;
        @(posedge clk);
        #1;
        paddr   = addr;
        pwrite  = write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        n = 0;
        @(negedge clk);
        while (!pready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!pready) begin
            $display("no pready within %0d cycles for address %h", WAIT_LIMIT, addr);
            failures++;
            finish_run();
        end else begin
            rdata = prdata;
            err   = pslverr;
            @(posedge clk);
            #1;
            psel    = 1'b0;
            penable = 1'b0;
        end
    endtask

    task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             output logic err);
        logic [DATA_W-1:0] rd;
        apb_transfer(1'b1, addr, data, rd, err);
    endtask

    task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                            output logic err);
        apb_transfer(1'b0, addr, '0, data, err);
    endtask

    // reads every modeled word of both targets
    task automatic verify_contents();
        logic [DATA_W-1:0] rd;
        logic              err;
        for (int w = 0; w < 7; w++) begin
            apb_read(ctrl_addr(w), rd, err);
            check_data($sformatf("ctrl word %0d", w), ctrl_model[w], rd);
            check_bit("pslverr", 1'b0, err);
        end
        for (int w = 1; w < 4; w++) begin
            apb_read(ext_addr(w), rd, err);
            check_data($sformatf("ext word %0d", w), ext_model[w], rd);
            check_bit("pslverr", 1'b0, err);
        end
    endtask

    task automatic regfile_roundtrip();
        logic [DATA_W-1:0] rd;
        logic              err;
        for (int w = 0; w < 7; w++) begin
            ctrl_model[w] = 32'h5eed_0000 | 32'(w * 32'h0000_0111 + 1);
            apb_write(ctrl_addr(w), ctrl_model[w], err);
            check_bit("pslverr", 1'b0, err);
        end
        verify_contents();
        apb_read(ctrl_addr(7), rd, err);
        check_data("ctrl word 7", HUB_ID, rd);
        apb_write(ctrl_addr(7), 32'hffff_ffff, err);
        apb_read(ctrl_addr(7), rd, err);
        check_data("ctrl word 7 after write", HUB_ID, rd);
    endtask

    task automatic unmapped_access();
        logic [DATA_W-1:0] rd;
        logic              err;
        apb_read(NONE_BASE | 16'h0004, rd, err);
        check_data("unmapped prdata", '0, rd);
        check_bit("pslverr", 1'b0, err);
        apb_write(NONE_BASE | 16'h0008, 32'hbad0_bad0, err);
        check_bit("pslverr", 1'b0, err);
        verify_contents();
    endtask

    task automatic ext_latency_access();
        logic [DATA_W-1:0] rd;
        logic              err;
        apb_write(ext_addr(0), 32'd5, err);
        for (int w = 1; w < 4; w++) begin
            ext_model[w] = 32'hface_0000 | 32'(w * 32'h0000_1010);
            apb_write(ext_addr(w), ext_model[w], err);
            check_bit("pslverr", 1'b0, err);
        end
        apb_read(ext_addr(0), rd, err);
        check_data("ext latency", 32'd5, rd);
        verify_contents();
    endtask

    task automatic timeout_recovery();
        logic [DATA_W-1:0] rd;
        logic              err;
        apb_write(ext_addr(0), 32'd200, err);
        // the write is dropped by the target, so word 2 keeps its value
        apb_write(ext_addr(2), 32'h0bad_cafe, err);
        check_bit("pslverr", 1'b1, err);
        apb_read(ext_addr(2), rd, err);
        check_bit("pslverr", 1'b1, err);
        check_data("prdata", TIMEOUT_DATA, rd);
        @(negedge clk);
        check_bit("interrupt", 1'b1, interrupt);
        check_addr("fault_addr", ext_addr(2), fault_addr);
        @(posedge clk);
        #1;
        clear = 1'b1;
        @(posedge clk);
        #1;
        clear = 1'b0;
        @(negedge clk);
        check_bit("interrupt", 1'b0, interrupt);
        check_addr("fault_addr", '0, fault_addr);
        apb_write(ext_addr(0), 32'd1, err);
        check_bit("pslverr", 1'b0, err);
        apb_read(ext_addr(2), rd, err);
        check_data("ext word 2", ext_model[2], rd);
    endtask

    task automatic random_traffic();
        logic [DATA_W-1:0] rd;
        logic [DATA_W-1:0] rnd;
        logic [ADDR_W-1:0] addr;
        logic              err;
        int                pick;
        for (int i = 0; i < 40; i++) begin
            // 0 to 6 pick a regfile word, 7 to 9 pick external words 1 to 3
            pick = $urandom % 10;
            rnd  = $urandom;
            addr = (pick < 7) ? ctrl_addr(pick) : ext_addr(pick - 6);
            if (rnd[0]) begin
                apb_write(addr, rnd, err);
                if (pick < 7) begin
                    ctrl_model[pick] = rnd;
                end else begin
                    ext_model[pick - 6] = rnd;
                end
            end else begin
                apb_read(addr, rd, err);
                check_data($sformatf("read of %h", addr),
                           (pick < 7) ? ctrl_model[pick] : ext_model[pick - 6], rd);
            end
            check_bit("pslverr", 1'b0, err);
        end
    endtask

    initial begin
        clk     = 1'b0;
        rstn    = 1'b0;
        paddr   = '0;
        pwrite  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwdata  = '0;
        clear   = 1'b0;
        mismatches = 0;
        failures   = 0;
        void'($urandom(SEED));
        for (int w = 0; w < 7; w++) begin
            ctrl_model[w] = '0;
        end
        for (int w = 1; w < 4; w++) begin
            ext_model[w] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(negedge clk);
        check_bit("pready", 1'b0, pready);
        check_bit("pslverr", 1'b0, pslverr);
        check_bit("interrupt", 1'b0, interrupt);
        check_addr("fault_addr", '0, fault_addr);
        regfile_roundtrip();
        unmapped_access();
        ext_latency_access();
        timeout_recovery();
        random_traffic();
        finish_run();
    end

endmodule

`default_nettype wire

//--- reg_hub_top.f
src/reg_hub_pkg.sv
src/apb_fsm.sv
src/slv_dispatch.sv
src/ctrl_regfile.sv
src/ext_reg_slave.sv
src/reg_hub_top.sv
bench/tb_reg_hub.sv

//--- src/apb_fsm.sv
`default_nettype none

module apb_fsm (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic [reg_hub_pkg::ADDR_W-1:0] paddr,
    input  logic                           pwrite,
    input  logic                           psel,
    input  logic                           penable,
    input  logic [reg_hub_pkg::DATA_W-1:0] pwdata,
    input  logic                           clear,
    input  logic                           req_rdy,
    input  logic                           ack_vld,
    input  logic [reg_hub_pkg::DATA_W-1:0] ack_rdata,
    input  logic                           ext_selected,
    output logic [reg_hub_pkg::DATA_W-1:0] prdata,
    output logic                           pready,
    output logic                           pslverr,
    output logic [reg_hub_pkg::ADDR_W-1:0] req_addr,
    output logic [reg_hub_pkg::DATA_W-1:0] req_wdata,
    output logic                           req_wr_en,
    output logic                           req_rd_en,
    output logic                           req_vld,
    output logic                           ack_rdy,
    output logic                           tgt_sync_reset,
    output logic                           interrupt,
    output logic [reg_hub_pkg::ADDR_W-1:0] fault_addr
);
    import reg_hub_pkg::*;

    fsm_state_t        state;
    fsm_state_t        next_state;
    logic              apb_setup;
    logic              leave_setup;
    logic              issue;
    logic              wait_next;
    logic [15:0]       cnt;
    logic              time_out;
    logic              ack_vld_q;
    logic [DATA_W-1:0] ack_rdata_q;

    assign apb_setup = psel & ~penable;
    assign leave_setup = (state == S_SETUP) && (next_state != S_SETUP);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= S_SETUP;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            S_SETUP: begin
                // unmapped addresses are answered inside the setup cycle
                if (apb_setup) begin
                    if (ack_vld) begin
                        next_state = S_ACCESS;
                    end else if (req_rdy) begin
                        next_state = S_WAIT_SLV_ACK;
                    end else begin
                        next_state = S_WAIT_SLV_RDY;
                    end
                end
            end
            S_WAIT_SLV_RDY: begin
                if (time_out) begin
                    next_state = S_SETUP;
                end else if (req_rdy) begin
                    // request taken this cycle, now wait for the ack
                    next_state = S_WAIT_SLV_ACK;
                end
            end
            S_WAIT_SLV_ACK: begin
                if (ack_vld || time_out) begin
                    next_state = S_SETUP;
                end
            end
            S_ACCESS: begin
                next_state = S_SETUP;
            end
            default: begin
                next_state = S_SETUP;
            end
        endcase
    end

    // one-cycle pulse for a ready target, held while the target is busy
    assign issue = (leave_setup && next_state == S_WAIT_SLV_ACK && ext_selected) ||
                   (next_state == S_WAIT_SLV_RDY);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            req_addr  <= '0;
            req_vld   <= 1'b0;
            req_wr_en <= 1'b0;
            req_rd_en <= 1'b0;
            ack_rdy   <= 1'b0;
        end else begin
            if (leave_setup) begin
                req_addr <= paddr;
            end
            req_vld   <= issue;
            req_wr_en <= issue & pwrite;
            req_rd_en <= issue & ~pwrite;
            ack_rdy   <= (next_state == S_WAIT_SLV_ACK);
        end
    end

    always_ff @(posedge clk) begin
        if (leave_setup) begin
            req_wdata <= pwdata;
        end
    end

    // timeout counter, only runs while a wait state is coming up
    assign wait_next = (next_state == S_WAIT_SLV_RDY) || (next_state == S_WAIT_SLV_ACK);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt      <= '0;
            time_out <= 1'b0;
        end else begin
            if (wait_next && cnt != TIMEOUT_CYCLES) begin
                cnt <= cnt + 16'd1;
            end else begin
                cnt <= '0;
            end
            time_out <= wait_next && (cnt == TIMEOUT_CYCLES);
        end
    end

    // sticky fault record, a new timeout beats clear
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            interrupt  <= 1'b0;
            fault_addr <= '0;
        end else if (time_out) begin
            interrupt  <= 1'b1;
            fault_addr <= req_addr;
        end else if (clear) begin
            interrupt  <= 1'b0;
            fault_addr <= '0;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ack_vld_q <= 1'b0;
        end else begin
            ack_vld_q <= ack_vld;
        end
    end

    always_ff @(posedge clk) begin
        ack_rdata_q <= ack_rdata;
    end

    assign tgt_sync_reset = time_out;
    assign pslverr = time_out;

    always_comb begin
        case (state)
            S_ACCESS: begin
                pready = ack_vld_q;
                prdata = ack_rdata_q;
            end
            S_SETUP: begin
                pready = 1'b0;
                prdata = ack_rdata;
            end
            default: begin
                pready = ack_vld | time_out;
                prdata = time_out ? TIMEOUT_DATA : ack_rdata;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/ctrl_regfile.sv
`default_nettype none

module ctrl_regfile (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           req_vld,
    input  logic [reg_hub_pkg::ADDR_W-1:0] req_addr,
    input  logic [reg_hub_pkg::DATA_W-1:0] req_wdata,
    input  logic                           req_wr_en,
    input  logic                           req_rd_en,
    input  logic                           ack_rdy,
    input  logic                           sync_reset,
    output logic                           req_rdy,
    output logic                           ack_vld,
    output logic [reg_hub_pkg::DATA_W-1:0] rdata
);
    import reg_hub_pkg::*;

    logic [DATA_W-1:0] regs [0:6];
    logic [2:0]        word;
    logic              accept;
    logic              ack_pend;

    // local bank never stalls
    assign req_rdy = 1'b1;
    assign word = req_addr[4:2];
    assign accept = req_vld & req_rdy & ~sync_reset;
    assign ack_vld = ack_pend & ack_rdy;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ack_pend <= 1'b0;
        end else if (sync_reset) begin
            ack_pend <= 1'b0;
        end else if (accept) begin
            ack_pend <= 1'b1;
        end else if (ack_vld) begin
            ack_pend <= 1'b0;
        end
    end

    // word 7 is the hub identity and drops writes
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < 7; i++) begin
                regs[i] <= '0;
            end
        end else if (accept && req_wr_en && word != 3'd7) begin
            regs[word] <= req_wdata;
        end
    end

    // read data captured with the request, presented with the ack
    always_ff @(posedge clk) begin
        if (accept && req_rd_en) begin
            if (word == 3'd7) begin
                rdata <= HUB_ID;
            end else begin
                rdata <= regs[word];
            end
        end
    end

endmodule

`default_nettype wire

//--- src/ext_reg_slave.sv
`default_nettype none

module ext_reg_slave (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           req_vld,
    input  logic [reg_hub_pkg::ADDR_W-1:0] req_addr,
    input  logic [reg_hub_pkg::DATA_W-1:0] req_wdata,
    input  logic                           req_wr_en,
    input  logic                           req_rd_en,
    input  logic                           ack_rdy,
    input  logic                           sync_reset,
    output logic                           req_rdy,
    output logic                           ack_vld,
    output logic [reg_hub_pkg::DATA_W-1:0] rdata
);
    import reg_hub_pkg::*;

    logic [7:0]        latency;
    logic [DATA_W-1:0] data_regs [1:3];
    logic [7:0]        cnt;
    logic [7:0]        load_val;
    logic [1:0]        word;
    logic              accept;
    logic [1:0]        p_word;
    logic [DATA_W-1:0] p_wdata;
    logic              p_wr;
    logic              p_rd;

    assign word = req_addr[3:2];
    assign req_rdy = (cnt == 8'd0);
    assign accept = req_vld & req_rdy & ~sync_reset;
    // word 0 is always fast so a stuck latency can be undone
    assign load_val = (word == 2'd0 || latency == 8'd0) ? 8'd1 : latency;
    assign ack_vld = (cnt == 8'd1) & ack_rdy & ~sync_reset;
    assign rdata = !p_rd ? '0 :
                   (p_word == 2'd0) ? {{(DATA_W-8){1'b0}}, latency} : data_regs[p_word];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt     <= '0;
            p_wr    <= 1'b0;
            p_rd    <= 1'b0;
            latency <= 8'd1;
            for (int i = 1; i < 4; i++) begin
                data_regs[i] <= '0;
            end
        end else begin
            if (sync_reset) begin
                cnt <= '0;
            end else if (accept) begin
                cnt <= load_val;
            end else if (ack_vld) begin
                cnt <= '0;
            end else if (cnt > 8'd1) begin
                cnt <= cnt - 8'd1;
            end
            if (accept) begin
                p_wr <= req_wr_en;
                p_rd <= req_rd_en;
            end
            // writes land only when the access completes
            if (ack_vld && p_wr) begin
                if (p_word == 2'd0) begin
                    latency <= p_wdata[7:0];
                end else begin
                    data_regs[p_word] <= p_wdata;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            p_word  <= word;
            p_wdata <= req_wdata;
        end
    end

endmodule

`default_nettype wire

//--- src/reg_hub_pkg.sv
`default_nettype none

package reg_hub_pkg;

    // bus widths
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;

    // wait-state cycles before an access is declared dead
    localparam logic [15:0] TIMEOUT_CYCLES = 16'd99;
    localparam logic [DATA_W-1:0] TIMEOUT_DATA = 32'hdead_1eaf;

    // identity word of the local register bank
    localparam logic [31:0] HUB_ID = 32'h4855_4231;

    // address bits 15:12 pick the target
    localparam logic [3:0] REGION_CTRL = 4'h0;
    localparam logic [3:0] REGION_EXT = 4'h1;

    typedef enum logic [1:0] {
        S_SETUP,
        S_WAIT_SLV_RDY,
        S_WAIT_SLV_ACK,
        S_ACCESS
    } fsm_state_t;

    typedef enum logic [1:0] {
        SEL_CTRL,
        SEL_EXT,
        SEL_NONE
    } slv_sel_t;

endpackage

`default_nettype wire

//--- src/reg_hub_top.sv
`default_nettype none

module reg_hub_top (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic [reg_hub_pkg::ADDR_W-1:0] paddr,
    input  logic                           pwrite,
    input  logic                           psel,
    input  logic                           penable,
    input  logic [reg_hub_pkg::DATA_W-1:0] pwdata,
    output logic [reg_hub_pkg::DATA_W-1:0] prdata,
    output logic                           pready,
    output logic                           pslverr,
    output logic                           interrupt,
    output logic [reg_hub_pkg::ADDR_W-1:0] fault_addr,
    input  logic                           clear
);
    import reg_hub_pkg::*;

    // apb_fsm to targets
    logic [ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0] req_wdata;
    logic              req_wr_en;
    logic              req_rd_en;
    logic              req_vld;
    logic              ack_rdy;
    logic              tgt_sync_reset;

    // muxed return path
    logic              req_rdy;
    logic              ack_vld;
    logic [DATA_W-1:0] ack_rdata;
    logic              ext_selected;

    // per-target lines
    logic              ctrl_req_vld;
    logic              ctrl_req_rdy;
    logic              ctrl_ack_vld;
    logic [DATA_W-1:0] ctrl_rdata;
    logic              ext_req_vld;
    logic              ext_req_rdy;
    logic              ext_ack_vld;
    logic [DATA_W-1:0] ext_rdata;

    apb_fsm u_apb_fsm (.*);

    slv_dispatch u_slv_dispatch (.*);

    ctrl_regfile u_ctrl_regfile (
        .*,
        .req_vld   (ctrl_req_vld),
        .req_rdy   (ctrl_req_rdy),
        .ack_vld   (ctrl_ack_vld),
        .rdata     (ctrl_rdata),
        .sync_reset(tgt_sync_reset)
    );

    ext_reg_slave u_ext_reg_slave (
        .*,
        .req_vld   (ext_req_vld),
        .req_rdy   (ext_req_rdy),
        .ack_vld   (ext_ack_vld),
        .rdata     (ext_rdata),
        .sync_reset(tgt_sync_reset)
    );

endmodule

`default_nettype wire

//--- src/slv_dispatch.sv
`default_nettype none

module slv_dispatch (
    input  logic [reg_hub_pkg::ADDR_W-1:0] req_addr,
    input  logic                           req_vld,
    input  logic                           ack_rdy,
    input  logic [reg_hub_pkg::ADDR_W-1:0] paddr,
    input  logic                           ctrl_req_rdy,
    input  logic                           ctrl_ack_vld,
    input  logic [reg_hub_pkg::DATA_W-1:0] ctrl_rdata,
    input  logic                           ext_req_rdy,
    input  logic                           ext_ack_vld,
    input  logic [reg_hub_pkg::DATA_W-1:0] ext_rdata,
    input  logic                           psel,
    input  logic                           penable,
    output logic                           ctrl_req_vld,
    output logic                           ext_req_vld,
    output logic                           req_rdy,
    output logic                           ack_vld,
    output logic [reg_hub_pkg::DATA_W-1:0] ack_rdata,
    output logic                           ext_selected
);
    import reg_hub_pkg::*;

    logic              apb_setup;
    logic [ADDR_W-1:0] dec_addr;
    logic [3:0]        region;
    slv_sel_t          sel;

    // live paddr in setup, latched request address after that
    assign apb_setup = psel & ~penable;
    assign dec_addr = apb_setup ? paddr : req_addr;
    assign region = dec_addr[ADDR_W-1 -: 4];

    always_comb begin
        case (region)
            REGION_CTRL: sel = SEL_CTRL;
            REGION_EXT:  sel = SEL_EXT;
            default:     sel = SEL_NONE;
        endcase
    end

    assign ext_selected = (sel != SEL_NONE);
    assign ctrl_req_vld = req_vld && (sel == SEL_CTRL);
    assign ext_req_vld = req_vld && (sel == SEL_EXT);

    always_comb begin
        case (sel)
            SEL_CTRL: begin
                req_rdy   = ctrl_req_rdy;
                ack_vld   = ack_rdy & ctrl_ack_vld;
                ack_rdata = ctrl_rdata;
            end
            SEL_EXT: begin
                req_rdy   = ext_req_rdy;
                ack_vld   = ack_rdy & ext_ack_vld;
                ack_rdata = ext_rdata;
            end
            default: begin
                // nobody home, reply with zero data right in setup
                req_rdy   = 1'b0;
                ack_vld   = apb_setup;
                ack_rdata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire
